//--- design/switch_pkg.sv
/*
 * Switch package
 * Port count, payload width, FIFO sizing and the packet format
 * shared by the buffers, the crossbar and the top level
 */
package switch_pkg;

  // Number of inputs, and also of outputs
  localparam int NUM_PORTS = 4;

  // Width of a port index
  localparam int PORT_W = 2;

  // Payload width
  localparam int DATA_W = 16;

  // Packets held per input FIFO
  localparam int FIFO_DEPTH = 8;

  // Fill count at which nearly_full rises
  localparam int NEARLY_FULL_LEVEL = 7;

  // Highest port index, where the round-robin pointers start
  localparam logic [PORT_W-1:0] LAST_PORT = PORT_W'(NUM_PORTS - 1);

  // Packet as it travels through the switch
  // valid is a one-cycle strobe on the wire
  typedef struct packed {
    logic              valid;
    logic [PORT_W-1:0] source;
    logic [PORT_W-1:0] dest;
    logic [DATA_W-1:0] data;
  } packet_t;

endpackage

//--- design/sched_pkg.sv
/*
 * Scheduler package
 * Request, grant and configuration types, plus the grant routing
 * that goes from the scheduler to the crossbar
 */
package sched_pkg;

  // Configuration addresses
  localparam logic CFG_ADDR_ENABLE = 1'b0;
  localparam logic CFG_ADDR_STATUS = 1'b1;

  // Head packet of an input wants output port
  typedef struct packed {
    logic                          valid;
    logic [switch_pkg::PORT_W-1:0] port;
  } req_t;

  // Pop the head and send it now (one FIFO per adapter)
  typedef struct packed {
    logic valid;
  } grant_t;

  // Configuration access, wr is a one-cycle strobe
  typedef struct packed {
    logic                             wr;
    logic                             addr;
    logic [switch_pkg::NUM_PORTS-1:0] wdata;
  } cfg_t;

  // Grant routing, per output a valid bit and the winning input
  // Only the scheduler and the crossbar use this
  typedef struct packed {
    logic [switch_pkg::NUM_PORTS-1:0]                            valid;
    logic [switch_pkg::NUM_PORTS-1:0][switch_pkg::PORT_W-1:0]    source;
  } route_t;

endpackage

//--- design/pkt_fifo.sv
/*
 * Packet FIFO, first-word fall-through
 * Head packet shows on dout while the FIFO is not empty
 * Flags full, nearly_full and empty come from a fill count
 */
`timescale 1ns/1ps

module pkt_fifo #(
  parameter int depth = switch_pkg::FIFO_DEPTH
) (
  input  logic                clk,
  input  logic                rst,
  input  switch_pkg::packet_t din,
  input  logic                wr_en,
  input  logic                rd_en,
  output switch_pkg::packet_t dout,
  output logic                full,
  output logic                nearly_full,
  output logic                empty
);

  localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
  localparam int CNT_W = $clog2(depth + 1);

  switch_pkg::packet_t mem [depth];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic                wr_ok;
  logic                rd_ok;

  // Wrap at depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // Writes while full and reads while empty are dropped
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_ok) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign dout        = mem[rd_ptr];
  assign empty       = (count == '0);
  assign full        = (count == CNT_W'(depth));
  assign nearly_full = (count >= CNT_W'(switch_pkg::NEARLY_FULL_LEVEL));

  a_no_read_empty: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
    else $error("pkt_fifo: read while empty");

  // Upstream must hold off while full, a write here is lost
  a_no_write_full: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
    else $error("pkt_fifo: write while full, packet dropped");

endmodule

//--- design/oeo_buffer.sv
/*
 * OEO input buffer
 * Queues incoming packets, requests the output named by the head
 * packet and sends the head one cycle after its grant
 */
`timescale 1ns/1ps

module oeo_buffer (
  input  logic                clk,
  input  logic                rst,
  input  switch_pkg::packet_t din,
  input  sched_pkg::grant_t   grant,
  output switch_pkg::packet_t dout,
  output sched_pkg::req_t     req,
  output logic                full,
  output logic                nearly_full
);

  switch_pkg::packet_t head;
  logic                empty;

  pkt_fifo #(
    .depth(switch_pkg::FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .rst         (rst),
    .din         (din),
    .wr_en       (din.valid),
    .rd_en       (grant.valid),
    .dout        (head),
    .full        (full),
    .nearly_full (nearly_full),
    .empty       (empty)
  );

  // Head is captured in the grant cycle, FIFO pops at the same edge
  always_ff @(posedge clk) begin
    if (grant.valid) begin
      dout <= head;
    end
    if (rst) begin
      dout.valid <= 1'b0;
    end else begin
      dout.valid <= grant.valid;
    end
  end

  // Request is a level, dropped for the grant cycle so that one
  // request cannot win twice
  always_comb begin
    req.valid = !empty && !grant.valid;
    req.port  = head.dest;
  end

  a_grant_after_req: assert property (
    @(posedge clk) disable iff (rst) grant.valid |-> $past(req.valid))
    else $error("oeo_buffer: grant without a request in the previous cycle");

endmodule

//--- design/port_scheduler.sv
/*
 * Port scheduler
 * Round-robin arbiter per output over the enabled requesting inputs
 * Grants and the output routing are registered
 */
`timescale 1ns/1ps

module port_scheduler (
  input  logic                                        clk,
  input  logic                                        rst,
  input  sched_pkg::req_t   [switch_pkg::NUM_PORTS-1:0] req,
  input  logic              [switch_pkg::NUM_PORTS-1:0] enable_mask,
  output sched_pkg::grant_t [switch_pkg::NUM_PORTS-1:0] grant,
  output sched_pkg::route_t                           route
);

  // Last winner per output
  logic [switch_pkg::NUM_PORTS-1:0][switch_pkg::PORT_W-1:0] ptr;
  logic [switch_pkg::NUM_PORTS-1:0]                         req_eff;
  logic [switch_pkg::NUM_PORTS-1:0]                         win_valid;
  logic [switch_pkg::NUM_PORTS-1:0][switch_pkg::PORT_W-1:0] win_src;
  sched_pkg::grant_t [switch_pkg::NUM_PORTS-1:0]            gnt_next;

  // Disabled inputs keep their packets queued
  always_comb begin
    for (int i = 0; i < switch_pkg::NUM_PORTS; i++) begin
      req_eff[i] = req[i].valid && enable_mask[i];
    end
  end

  // Search starts just after the last winner and wraps around
  always_comb begin
    int idx;
    win_valid = '0;
    win_src   = '0;
    for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
      for (int off = 1; off <= switch_pkg::NUM_PORTS; off++) begin
        idx = (int'(ptr[p]) + off) % switch_pkg::NUM_PORTS;
        if (!win_valid[p] && req_eff[idx] && (int'(req[idx].port) == p)) begin
          win_valid[p] = 1'b1;
          win_src[p]   = idx[switch_pkg::PORT_W-1:0];
        end
      end
    end
  end

  // Each input asks for one output, so it wins at most once
  always_comb begin
    gnt_next = '0;
    for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
      if (win_valid[p]) begin
        gnt_next[win_src[p]].valid = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant        <= '0;
      route.valid  <= '0;
      route.source <= '0;
      for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
        ptr[p] <= switch_pkg::LAST_PORT;
      end
    end else begin
      grant        <= gnt_next;
      route.valid  <= win_valid;
      route.source <= win_src;
      for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
        if (win_valid[p]) begin
          ptr[p] <= win_src[p];
        end
      end
    end
  end

  // Every granted input drives exactly one output
  a_grant_count: assert property (
    @(posedge clk) disable iff (rst) $countones(grant) == $countones(route.valid))
    else $error("port_scheduler: grant count differs from routed outputs");

  for (genvar p = 0; p < switch_pkg::NUM_PORTS; p++) begin : g_chk
    for (genvar q = p + 1; q < switch_pkg::NUM_PORTS; q++) begin : g_pair
      a_one_per_input: assert property (
        @(posedge clk) disable iff (rst)
        !(route.valid[p] && route.valid[q] && route.source[p] == route.source[q]))
        else $error("port_scheduler: outputs %0d and %0d share an input", p, q);
    end
  end

endmodule

//--- design/sched_config.sv
/*
 * Scheduler configuration
 * Holds the per-input enable mask with write and readback,
 * and exposes the live request levels as a status word
 */
`timescale 1ns/1ps

module sched_config (
  input  logic                             clk,
  input  logic                             rst,
  input  sched_pkg::cfg_t                  cfg,
  input  logic [switch_pkg::NUM_PORTS-1:0] req_levels,
  output logic [switch_pkg::NUM_PORTS-1:0] enable_mask,
  output logic [switch_pkg::NUM_PORTS-1:0] cfg_rdata
);

  logic [switch_pkg::NUM_PORTS-1:0] enable_q;

  // All inputs enabled out of reset, status address is read only
  always_ff @(posedge clk) begin
    if (rst) begin
      enable_q <= '1;
    end else if (cfg.wr && (cfg.addr == sched_pkg::CFG_ADDR_ENABLE)) begin
      enable_q <= cfg.wdata;
    end
  end

  assign enable_mask = enable_q;

  // Readback follows addr in the same cycle
  always_comb begin
    case (cfg.addr)
      sched_pkg::CFG_ADDR_STATUS: cfg_rdata = req_levels;
      default:                    cfg_rdata = enable_q;
    endcase
  end

endmodule

//--- design/switch_crossbar.sv
/*
 * Output crossbar
 * Registers the grant routing alongside the buffer outputs and
 * steers each routed buffer onto its output port
 */
`timescale 1ns/1ps

module switch_crossbar (
  input  logic                                          clk,
  input  logic                                          rst,
  input  sched_pkg::route_t                             route,
  input  switch_pkg::packet_t [switch_pkg::NUM_PORTS-1:0] bufout,
  output switch_pkg::packet_t [switch_pkg::NUM_PORTS-1:0] out
);

  sched_pkg::route_t route_q;

  // Same edge at which the buffers register their heads
  always_ff @(posedge clk) begin
    route_q <= route;
    if (rst) begin
      route_q.valid <= '0;
    end
  end

  // Unrouted outputs stay idle
  always_comb begin
    for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
      out[p] = '0;
      if (route_q.valid[p]) begin
        out[p] = bufout[route_q.source[p]];
      end
    end
  end

  for (genvar p = 0; p < switch_pkg::NUM_PORTS; p++) begin : g_chk
    a_routed_valid: assert property (
      @(posedge clk) disable iff (rst)
      route_q.valid[p] |-> bufout[route_q.source[p]].valid)
      else $error("switch_crossbar: output %0d routed to an idle buffer", p);
  end

endmodule

//--- design/oeo_switch_top.sv
/*
 * OEO switch slice, four ports
 * Input buffers, round-robin scheduler, enable configuration
 * and output crossbar
 */
`timescale 1ns/1ps

module oeo_switch_top (
  input  logic                                            clk,
  input  logic                                            rst,
  input  switch_pkg::packet_t [switch_pkg::NUM_PORTS-1:0] din,
  input  sched_pkg::cfg_t                                 cfg,
  output switch_pkg::packet_t [switch_pkg::NUM_PORTS-1:0] out,
  output logic                [switch_pkg::NUM_PORTS-1:0] full,
  output logic                [switch_pkg::NUM_PORTS-1:0] nearly_full,
  output logic                [switch_pkg::NUM_PORTS-1:0] cfg_rdata
);

  sched_pkg::req_t     [switch_pkg::NUM_PORTS-1:0] req;
  sched_pkg::grant_t   [switch_pkg::NUM_PORTS-1:0] grant;
  switch_pkg::packet_t [switch_pkg::NUM_PORTS-1:0] bufout;
  sched_pkg::route_t                               route;
  logic                [switch_pkg::NUM_PORTS-1:0] req_levels;
  logic                [switch_pkg::NUM_PORTS-1:0] enable_mask;

  for (genvar i = 0; i < switch_pkg::NUM_PORTS; i++) begin : g_in
    oeo_buffer u_buf (
      .clk         (clk),
      .rst         (rst),
      .din         (din[i]),
      .grant       (grant[i]),
      .dout        (bufout[i]),
      .req         (req[i]),
      .full        (full[i]),
      .nearly_full (nearly_full[i])
    );
    assign req_levels[i] = req[i].valid;
  end

  port_scheduler u_sched (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .enable_mask (enable_mask),
    .grant       (grant),
    .route       (route)
  );

  sched_config u_cfg (
    .clk         (clk),
    .rst         (rst),
    .cfg         (cfg),
    .req_levels  (req_levels),
    .enable_mask (enable_mask),
    .cfg_rdata   (cfg_rdata)
  );

  switch_crossbar u_xbar (
    .clk    (clk),
    .rst    (rst),
    .route  (route),
    .bufout (bufout),
    .out    (out)
  );

endmodule

//--- tests/tb_oeo_switch.sv
/*
 * Testbench for the four-port OEO switch slice
 * Applies a stimulus table and random traffic, and checks every cycle
 * against a model of the FIFOs, the request rule and the round-robin pointers
 */
`timescale 1ns/1ps

module tb_oeo_switch;

  localparam int NP = switch_pkg::NUM_PORTS;
  localparam logic [1:0] KIND_PKT = 2'd0;
  localparam logic [1:0] KIND_CFG_WR = 2'd1;
  localparam logic [1:0] KIND_CFG_RD = 2'd2;
  localparam int NUM_STIM = 16;

  // Entry waits gap idle cycles and then repeats for count cycles in a row
  typedef struct packed {
    logic [3:0] gap;
    logic [3:0] count;
    logic [1:0] kind;
    logic [1:0] inp;
    logic [1:0] dest;
    logic [3:0] val;
  } stim_t;

  logic                         clk;
  logic                         rst;
  switch_pkg::packet_t [NP-1:0] din;
  sched_pkg::cfg_t              cfg;
  switch_pkg::packet_t [NP-1:0] out;
  logic [NP-1:0]                full;
  logic [NP-1:0]                nearly_full;
  logic [NP-1:0]                cfg_rdata;

  // Model state with one entry per input or per output
  switch_pkg::packet_t          mq [NP][$];
  switch_pkg::packet_t          m_bo [NP];
  logic [NP-1:0]                m_gnt;
  logic [NP-1:0]                m_rv;
  logic [NP-1:0]                m_xv;
  logic [NP-1:0]                m_en;
  int                           m_rs [NP];
  int                           m_xs [NP];
  int                           m_ptr [NP];

  switch_pkg::packet_t [NP-1:0] out_snap;
  logic [NP-1:0]                rdata_snap;
  int                           cyc = 0;
  int                           out_cyc = 0;
  int                           checks = 0;
  int                           errors = 0;
  int                           timeouts = 0;
  int                           written = 0;
  int                           received = 0;

  stim_t stim_tbl [NUM_STIM] = '{
    // Four inputs to output 3, then a second wave that wraps the pointer
    '{4'd2,  4'd1, KIND_PKT,    2'd0, 2'd3, 4'h0},
    '{4'd0,  4'd1, KIND_PKT,    2'd1, 2'd3, 4'h0},
    '{4'd0,  4'd1, KIND_PKT,    2'd2, 2'd3, 4'h0},
    '{4'd0,  4'd1, KIND_PKT,    2'd3, 2'd3, 4'h0},
    '{4'd12, 4'd1, KIND_PKT,    2'd2, 2'd3, 4'h0},
    '{4'd0,  4'd1, KIND_PKT,    2'd3, 2'd3, 4'h0},
    '{4'd0,  4'd1, KIND_PKT,    2'd0, 2'd3, 4'h0},
    // Distinct outputs in one cycle, then a stream on input 2
    '{4'd12, 4'd1, KIND_PKT,    2'd0, 2'd1, 4'h0},
    '{4'd0,  4'd1, KIND_PKT,    2'd1, 2'd2, 4'h0},
    '{4'd0,  4'd1, KIND_PKT,    2'd2, 2'd3, 4'h0},
    '{4'd0,  4'd1, KIND_PKT,    2'd3, 2'd0, 4'h0},
    '{4'd6,  4'd4, KIND_PKT,    2'd2, 2'd0, 4'h0},
    // Input 1 disabled and filled, status read, then released
    '{4'd12, 4'd1, KIND_CFG_WR, 2'd0, 2'd0, 4'b1101},
    '{4'd1,  4'd8, KIND_PKT,    2'd1, 2'd2, 4'h0},
    '{4'd1,  4'd1, KIND_CFG_RD, 2'd0, 2'd0, 4'h1},
    '{4'd3,  4'd1, KIND_CFG_WR, 2'd0, 2'd0, 4'b1111}
  };

  oeo_switch_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .din         (din),
    .cfg         (cfg),
    .out         (out),
    .full        (full),
    .nearly_full (nearly_full),
    .cfg_rdata   (cfg_rdata)
  );

  always #20 clk = ~clk;

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic model_reset();
    for (int i = 0; i < NP; i++) begin
      mq[i].delete();
      m_bo[i]  = '0;
      m_rs[i]  = 0;
      m_xs[i]  = 0;
      m_ptr[i] = NP - 1;
    end
    m_gnt = '0;
    m_rv  = '0;
    m_xv  = '0;
    m_en  = '1;
  endtask

  // Compare the outputs of this cycle, then advance the model by one edge
  task automatic model_cycle();
    switch_pkg::packet_t exp_pkt;
    logic [NP-1:0]       req;
    logic [NP-1:0]       exp_full;
    logic [NP-1:0]       exp_nf;
    logic [NP-1:0]       wv;
    int                  ws [NP];
    int                  idx;
    for (int i = 0; i < NP; i++) begin
      req[i]      = (mq[i].size() > 0) && !m_gnt[i];
      exp_full[i] = (mq[i].size() == switch_pkg::FIFO_DEPTH);
      exp_nf[i]   = (mq[i].size() >= switch_pkg::NEARLY_FULL_LEVEL);
    end
    for (int p = 0; p < NP; p++) begin
      exp_pkt = m_xv[p] ? m_bo[m_xs[p]] : '0;
      check_val(32'(out[p]), 32'(exp_pkt), $sformatf("out[%0d]", p));
      if (out[p].valid) begin
        received++;
      end
    end
    check_val(32'(full), 32'(exp_full), "full");
    check_val(32'(nearly_full), 32'(exp_nf), "nearly_full");
    check_val(32'(cfg_rdata), 32'(cfg.addr ? req : m_en), "cfg_rdata");
    // First enabled requester after the last winner of each output
    wv = '0;
    for (int p = 0; p < NP; p++) begin
      ws[p] = 0;
      for (int off = 1; off <= NP; off++) begin
        idx = (m_ptr[p] + off) % NP;
        if (!wv[p] && req[idx] && m_en[idx] && (int'(mq[idx][0].dest) == p)) begin
          wv[p] = 1'b1;
          ws[p] = idx;
        end
      end
    end
    m_xv = m_rv;
    m_xs = m_rs;
    for (int i = 0; i < NP; i++) begin
      if (m_gnt[i]) begin
        m_bo[i] = mq[i].pop_front();
      end
      m_bo[i].valid = m_gnt[i];
      if (din[i].valid && !exp_full[i]) begin
        mq[i].push_back(din[i]);
        written++;
      end
    end
    m_gnt = '0;
    for (int p = 0; p < NP; p++) begin
      m_rv[p] = wv[p];
      m_rs[p] = ws[p];
      if (wv[p]) begin
        m_gnt[ws[p]] = 1'b1;
        m_ptr[p]     = ws[p];
      end
    end
    if (cfg.wr && (cfg.addr == sched_pkg::CFG_ADDR_ENABLE)) begin
      m_en = cfg.wdata;
    end
  endtask

  // Sample at the falling edge, then clear the strobes after the rising edge
  task automatic next_cycle();
    @(negedge clk);
    out_snap   = out;
    rdata_snap = cfg_rdata;
    out_cyc    = cyc;
    model_cycle();
    @(posedge clk);
    cyc++;
    for (int i = 0; i < NP; i++) begin
      din[i] <= '0;
    end
    cfg.wr <= 1'b0;
  endtask

  task automatic send_packet(input int inp, input int dest);
    switch_pkg::packet_t pkt;
    logic [31:0]         r;
    r          = $urandom;
    pkt.valid  = 1'b1;
    pkt.source = inp[switch_pkg::PORT_W-1:0];
    pkt.dest   = dest[switch_pkg::PORT_W-1:0];
    pkt.data   = r[switch_pkg::DATA_W-1:0];
    din[inp] <= pkt;
  endtask

  function automatic logic model_busy();
    logic busy;
    busy = (m_gnt != '0) || (m_rv != '0) || (m_xv != '0);
    for (int i = 0; i < NP; i++) begin
      if (mq[i].size() > 0) begin
        busy = 1'b1;
      end
    end
    return busy;
  endfunction

  initial begin
    int    n;
    int    din_cyc;
    stim_t s;
    clk = 1'b0;
    rst = 1'b1;
    din = '0;
    cfg = '0;
    void'($urandom(32'hc73d_e761));
    model_reset();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    next_cycle();
    check_val(32'(rdata_snap), 32'({NP{1'b1}}), "enable mask after reset");

    // Single packet on an idle switch, the din edge ends this cycle
    send_packet(1, 2);
    din_cyc = cyc;
    n = 0;
    while (!out_snap[2].valid && n < 20) begin
      next_cycle();
      n++;
    end
    if (out_snap[2].valid) begin
      check_val(out_cyc - din_cyc, 32'd3, "latency on an idle switch");
    end else begin
      timeouts++;
      $display("Timeout: packet from input 1 never reached output 2");
    end

    for (int k = 0; k < NUM_STIM; k++) begin
      s = stim_tbl[k];
      repeat (s.gap) next_cycle();
      for (int c = 0; c < int'(s.count); c++) begin
        if (c > 0) begin
          next_cycle();
        end
        case (s.kind)
          KIND_PKT: send_packet(int'(s.inp), int'(s.dest));
          KIND_CFG_WR: begin
            cfg.wr    <= 1'b1;
            cfg.addr  <= sched_pkg::CFG_ADDR_ENABLE;
            cfg.wdata <= s.val;
          end
          KIND_CFG_RD: cfg.addr <= s.val[0];
        endcase
      end
    end

    // Random traffic that never writes a full input
    for (int c = 0; c < 300; c++) begin
      for (int i = 0; i < NP; i++) begin
        if ((($urandom % 3) == 0) && (mq[i].size() < switch_pkg::FIFO_DEPTH)) begin
          send_packet(i, int'($urandom % NP));
        end
      end
      if (($urandom % 8) == 0) begin
        cfg.addr <= !cfg.addr;
      end
      next_cycle();
    end

    n = 0;
    while (model_busy() && n < 100) begin
      next_cycle();
      n++;
    end
    if (model_busy()) begin
      timeouts++;
      $display("Timeout: switch still held packets after 100 drain cycles");
    end
    check_val(received, written, "packets delivered against packets written");
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- list.f
design/switch_pkg.sv
design/sched_pkg.sv
design/pkt_fifo.sv
design/oeo_buffer.sv
design/port_scheduler.sv
design/sched_config.sv
design/switch_crossbar.sv
design/oeo_switch_top.sv
tests/tb_oeo_switch.sv

//--- run.sh
#!/bin/sh
# Build and run the OEO switch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_oeo_switch -f list.f -o sim_oeo_switch

./obj_dir/sim_oeo_switch > sim.log 2>&1 || true
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
  echo "Simulation PASS"
  exit 0
fi
echo "Simulation FAIL"
exit 1
